/* chirp_params.svh */
// **********************************************************
// Chirp generator widths and sizes
// Shared by the package and every RTL block
// **********************************************************
`ifndef CHIRP_PARAMS_SVH
`define CHIRP_PARAMS_SVH

// Wishbone word address and data widths
`define CHIRP_AW 4
`define CHIRP_DW 32

// Number of decoded register words
`define CHIRP_NREGS 8

// Burst duration and strobe divider counters
`define CHIRP_CW 32

// Envelope amplitude, unsigned
`define CHIRP_AMPW 16

// Frequency word and phase accumulator
`define CHIRP_FW 24
`define CHIRP_PW 24

// Signed output sample
`define CHIRP_SW 16

`endif

/* chirp_pkg.sv */
// **********************************************************
// Chirp generator shared types
// Register map, CTRL word layout and STATUS bit positions
// **********************************************************
`include "chirp_params.svh"

package chirp_pkg;

	// Word addresses on the Wishbone port
	typedef enum logic [`CHIRP_AW-1:0] {
		CTRL       = 0,
		STATUS     = 1,
		DURATION   = 2,
		AMP_SLOPE  = 3,
		AMP_MAX    = 4,
		FREQ_START = 5,
		FREQ_STEP  = 6,
		RATE       = 7
	} reg_addr_t;

	// CTRL word, both bits act as strobes
	typedef struct packed {
		logic [`CHIRP_DW-3:0] reserved;
		logic                 clear_flags;
		logic                 start;
	} ctrl_t;

	// STATUS word bit positions
	localparam int STAT_BUSY    = 0;
	localparam int STAT_ERROR   = 1;
	localparam int STAT_WARNING = 2;

endpackage

/* chirp_cfg_if.sv */
// **********************************************************
// Chirp burst configuration bundle
// Settings and start out of the registers, status back in
// **********************************************************
`timescale 1ns/1ps
`include "chirp_params.svh"

interface chirp_cfg_if;

	// Programmed burst settings
	logic [`CHIRP_CW-1:0]   duration;
	logic [`CHIRP_AMPW-1:0] amp_slope;
	logic [`CHIRP_AMPW-1:0] amp_max;
	logic [`CHIRP_FW-1:0]   freq_start;
	logic [`CHIRP_FW-1:0]   freq_step;
	logic [`CHIRP_CW-1:0]   rate;
	// One-cycle start pulse
	logic start;
	// Returned by the envelope
	logic busy;
	logic error;
	logic warning;

	modport regs (output duration, amp_slope, amp_max, freq_start, freq_step, rate, start,
		input busy, error, warning);
	modport env (input duration, amp_slope, amp_max, start, output busy, error, warning);
	modport sweep (input freq_start, freq_step, rate, start, busy);
	modport shaper (input amp_max, busy);

endinterface

/* chirp_wb_regs.sv */
// **********************************************************
// Chirp register block on a Wishbone classic slave
// Settings, start pulse and sticky status flags
// **********************************************************
`timescale 1ns/1ps
`include "chirp_params.svh"

module chirp_wb_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [`CHIRP_AW-1:0] wb_adr,
	input  logic [`CHIRP_DW-1:0] wb_dat_w,
	output logic                 wb_ack,
	output logic [`CHIRP_DW-1:0] wb_dat_r,
	chirp_cfg_if.regs            cfg
);

	chirp_pkg::reg_addr_t addr;
	chirp_pkg::ctrl_t     ctrl_w;
	logic                 access;
	logic                 wr;
	logic                 in_range;
	logic                 clear;
	logic                 err_sticky;
	logic                 warn_sticky;
	logic [`CHIRP_DW-1:0] status_word;
	logic [`CHIRP_DW-1:0] rd_data;

	// New request, one ack per cyc/stb
	assign access   = wb_cyc & wb_stb & ~wb_ack;
	assign wr       = access & wb_we;
	assign addr     = chirp_pkg::reg_addr_t'(wb_adr);
	assign in_range = wb_adr < `CHIRP_NREGS;
	assign ctrl_w   = chirp_pkg::ctrl_t'(wb_dat_w);
	assign clear    = wr & (addr == chirp_pkg::CTRL) & ctrl_w.clear_flags;

	// Ack for exactly one cycle, never stalls
	always_ff @(posedge clk) begin
		if (reset)
			wb_ack <= 1'b0;
		else
			wb_ack <= access;
	end

	// Start pulse follows an acked CTRL write with bit 0 set
	always_ff @(posedge clk) begin
		if (reset)
			cfg.start <= 1'b0;
		else
			cfg.start <= wr & (addr == chirp_pkg::CTRL) & ctrl_w.start;
	end

	// Settings registers, whole-word writes
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg.duration   <= '0;
			cfg.amp_slope  <= '0;
			cfg.amp_max    <= '0;
			cfg.freq_start <= '0;
			cfg.freq_step  <= '0;
			cfg.rate       <= '0;
		end else if (wr & in_range) begin
			case (addr)
				chirp_pkg::DURATION:   cfg.duration   <= wb_dat_w[`CHIRP_CW-1:0];
				chirp_pkg::AMP_SLOPE:  cfg.amp_slope  <= wb_dat_w[`CHIRP_AMPW-1:0];
				chirp_pkg::AMP_MAX:    cfg.amp_max    <= wb_dat_w[`CHIRP_AMPW-1:0];
				chirp_pkg::FREQ_START: cfg.freq_start <= wb_dat_w[`CHIRP_FW-1:0];
				chirp_pkg::FREQ_STEP:  cfg.freq_step  <= wb_dat_w[`CHIRP_FW-1:0];
				chirp_pkg::RATE:       cfg.rate       <= wb_dat_w[`CHIRP_CW-1:0];
				// CTRL holds strobes only, STATUS is read-only
				default: ;
			endcase
		end
	end

	// Error and warning stick until clear_flags
	always_ff @(posedge clk) begin
		if (reset) begin
			err_sticky  <= 1'b0;
			warn_sticky <= 1'b0;
		end else begin
			err_sticky  <= (err_sticky & ~clear) | cfg.error;
			warn_sticky <= (warn_sticky & ~clear) | cfg.warning;
		end
	end

	// busy is live, not sticky
	always_comb begin
		status_word = '0;
		status_word[chirp_pkg::STAT_BUSY]    = cfg.busy;
		status_word[chirp_pkg::STAT_ERROR]   = err_sticky;
		status_word[chirp_pkg::STAT_WARNING] = warn_sticky;
	end

	// Read mux, unmapped words read zero
	always_comb begin
		rd_data = '0;
		if (in_range) begin
			case (addr)
				chirp_pkg::STATUS:     rd_data = status_word;
				chirp_pkg::DURATION:   rd_data = cfg.duration;
				chirp_pkg::AMP_SLOPE:  rd_data = {{(`CHIRP_DW-`CHIRP_AMPW){1'b0}}, cfg.amp_slope};
				chirp_pkg::AMP_MAX:    rd_data = {{(`CHIRP_DW-`CHIRP_AMPW){1'b0}}, cfg.amp_max};
				chirp_pkg::FREQ_START: rd_data = {{(`CHIRP_DW-`CHIRP_FW){1'b0}}, cfg.freq_start};
				chirp_pkg::FREQ_STEP:  rd_data = {{(`CHIRP_DW-`CHIRP_FW){1'b0}}, cfg.freq_step};
				chirp_pkg::RATE:       rd_data = cfg.rate;
				default:               rd_data = '0;
			endcase
		end
	end

	// Read data captured on the ack edge
	always_ff @(posedge clk) begin
		if (access & ~wb_we)
			wb_dat_r <= rd_data;
	end

endmodule

/* chirp_envelope.sv */
// **********************************************************
// Chirp amplitude envelope with ramped edges
// Rise to a ceiling, hold, then fall back to zero in time
// **********************************************************
`timescale 1ns/1ps
`include "chirp_params.svh"

module chirp_envelope (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   gate,
	chirp_cfg_if.env               cfg,
	output logic [`CHIRP_AMPW-1:0] amp,
	output logic                   gate_d
);

	logic                   arm_d;
	logic                   pulse_on;
	logic [`CHIRP_CW-1:0]   counter;
	logic [`CHIRP_CW-1:0]   rise_cnt;
	logic [`CHIRP_CW-1:0]   rise_t;
	logic [`CHIRP_AMPW:0]   amp_step;
	logic [`CHIRP_AMPW-1:0] amp_flat;
	logic                   railed;

	// Rail is the ceiling while on, zero while falling
	assign amp_flat = pulse_on ? cfg.amp_max : '0;
	// Overshoot going up, borrow going down
	assign railed = pulse_on ? (amp_step >= {1'b0, cfg.amp_max}) : amp_step[`CHIRP_AMPW];

	// Add/subtract one cycle ahead of the gate
	// Needs a non-gate cycle between gates
	always_ff @(posedge clk) begin
		amp_step <= pulse_on ? {1'b0, amp} + {1'b0, cfg.amp_slope}
			: {1'b0, amp} - {1'b0, cfg.amp_slope};
	end

	// Burst control, duration counter and busy
	always_ff @(posedge clk) begin
		if (reset) begin
			arm_d    <= 1'b0;
			pulse_on <= 1'b0;
			counter  <= '0;
			cfg.busy <= 1'b0;
		end else begin
			arm_d <= cfg.start;
			if (cfg.start) begin
				counter  <= cfg.duration;
				pulse_on <= 1'b0;
				cfg.busy <= 1'b1;
			end else begin
				// Pulse on one cycle after the start edge
				if (arm_d)
					pulse_on <= 1'b1;
				// Fall early by the measured rise time
				else if (gate & pulse_on & (counter <= rise_t))
					pulse_on <= 1'b0;
				if (gate & (counter != '0))
					counter <= counter - 1'b1;
				// Done once count and amplitude are both spent
				if (~arm_d & ~pulse_on & (counter == '0) & (amp == '0))
					cfg.busy <= 1'b0;
			end
		end
	end

	// Amplitude moves on gate cycles only
	always_ff @(posedge clk) begin
		if (reset | cfg.start)
			amp <= '0;
		else if (gate)
			amp <= railed ? amp_flat : amp_step[`CHIRP_AMPW-1:0];
	end

	// Rise time in strobes, plus two for margin
	always_ff @(posedge clk) begin
		if (reset | cfg.start) begin
			rise_cnt <= '0;
			rise_t   <= '0;
		end else if (pulse_on & gate) begin
			if (!railed)
				rise_cnt <= rise_cnt + 1'b1;
			else
				rise_t <= rise_cnt + 2;
		end
	end

	// Back-to-back gates break the step pipeline
	// Restart with amplitude still up is a warning
	always_ff @(posedge clk) begin
		if (reset) begin
			gate_d      <= 1'b0;
			cfg.error   <= 1'b0;
			cfg.warning <= 1'b0;
		end else begin
			gate_d      <= gate;
			cfg.error   <= gate & gate_d;
			cfg.warning <= cfg.start & (amp != '0);
		end
	end

endmodule

/* chirp_sweep.sv */
// **********************************************************
// Chirp sweep, strobe divider and linear frequency ramp
// Accumulates phase once per strobe
// **********************************************************
`timescale 1ns/1ps
`include "chirp_params.svh"

module chirp_sweep (
	input  logic                 clk,
	input  logic                 reset,
	chirp_cfg_if.sweep           cfg,
	output logic                 gate,
	output logic [`CHIRP_FW-1:0] freq,
	output logic [`CHIRP_PW-1:0] phase
);

	logic [`CHIRP_CW-1:0] div_cnt;
	logic [`CHIRP_CW-1:0] reload;
	logic                 first;
	logic [`CHIRP_FW-1:0] freq_next;

	// Period of RATE clocks, 0 and 1 both give every clock
	assign reload = (cfg.rate > 1) ? cfg.rate - 1'b1 : '0;

	// Strobe divider, restarted by start
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			gate    <= 1'b0;
		end else if (cfg.start) begin
			div_cnt <= reload;
			gate    <= 1'b0;
		end else if (cfg.busy) begin
			if (div_cnt == '0) begin
				div_cnt <= reload;
				gate    <= 1'b1;
			end else begin
				div_cnt <= div_cnt - 1'b1;
				gate    <= 1'b0;
			end
		end else begin
			gate <= 1'b0;
		end
	end

	// First strobe loads FREQ_START, later ones step it
	// Step is two's complement, wraps modulo the word width
	assign freq_next = first ? cfg.freq_start : freq + cfg.freq_step;

	always_ff @(posedge clk) begin
		if (reset) begin
			first <= 1'b0;
			freq  <= '0;
			phase <= '0;
		end else if (cfg.start) begin
			first <= 1'b1;
			phase <= '0;
		end else if (gate) begin
			first <= 1'b0;
			freq  <= freq_next;
			// Phase advances by the new frequency word
			phase <= phase + `CHIRP_PW'(freq_next);
		end
	end

endmodule

/* chirp_shaper.sv */
// **********************************************************
// Chirp waveform shaper
// Parabolic sine from the phase, scaled by the envelope
// **********************************************************
`timescale 1ns/1ps
`include "chirp_params.svh"

module chirp_shaper (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          gate_d,
	input  logic [`CHIRP_PW-1:0]          phase,
	input  logic [`CHIRP_AMPW-1:0]        amp,
	output logic signed [`CHIRP_SW-1:0]   sample,
	output logic                          sample_valid
);

	localparam int MW = `CHIRP_SW - 1;

	logic [`CHIRP_SW-1:0]        x;
	logic [`CHIRP_SW-1:0]        x_inv;
	logic [2*`CHIRP_SW-1:0]      para;
	logic [MW-1:0]               mag1;
	logic                        neg1;
	logic [`CHIRP_AMPW-1:0]      amp1;
	logic                        valid1;
	logic [MW+`CHIRP_AMPW-1:0]   prod;
	logic [MW-1:0]               mag2;

	// Position within the half wave
	// The MSB gives the sign
	assign x = phase[`CHIRP_PW-2 -: `CHIRP_SW];
	// ~x stands in for 1-x in x*(1-x)
	assign x_inv = ~x;
	assign para  = x * x_inv;

	// Stage one keeps four times the parabola, which peaks at 1/4
	always_ff @(posedge clk) begin
		mag1 <= para[2*`CHIRP_SW-3 -: MW];
		neg1 <= phase[`CHIRP_PW-1];
		amp1 <= amp;
	end

	// Stage two scales by the amplitude
	assign prod = mag1 * amp1;
	assign mag2 = prod[MW+`CHIRP_AMPW-1 -: MW];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid1       <= 1'b0;
			sample_valid <= 1'b0;
			sample       <= '0;
		end else begin
			// Every stage advances each cycle
			// so strobes on adjacent cycles both pass through
			valid1       <= gate_d;
			sample_valid <= valid1;
			if (valid1) begin
				// Negative half of the wave
				if (neg1)
					sample <= -$signed({1'b0, mag2});
				else
					sample <= $signed({1'b0, mag2});
			end
		end
	end

endmodule

/* chirp_gen.sv */
// **********************************************************
// Linear chirp burst generator, top level
// Wishbone registers, sweep, envelope and shaper
// **********************************************************
`timescale 1ns/1ps
`include "chirp_params.svh"

module chirp_gen (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [`CHIRP_AW-1:0]          wb_adr,
	input  logic [`CHIRP_DW-1:0]          wb_dat_w,
	output logic                          wb_ack,
	output logic [`CHIRP_DW-1:0]          wb_dat_r,
	output logic [`CHIRP_FW-1:0]          freq,
	output logic [`CHIRP_AMPW-1:0]        amp,
	output logic signed [`CHIRP_SW-1:0]   sample,
	output logic                          sample_valid,
	output logic                          busy
);

	// Strobe and its copy aligned with the new amplitude
	logic                 gate;
	logic                 gate_d;
	logic [`CHIRP_PW-1:0] phase;

	chirp_cfg_if cfg_if ();

	chirp_wb_regs regs_i (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_ack   (wb_ack),
		.wb_dat_r (wb_dat_r),
		.cfg      (cfg_if.regs)
	);

	chirp_sweep sweep_i (
		.clk   (clk),
		.reset (reset),
		.cfg   (cfg_if.sweep),
		.gate  (gate),
		.freq  (freq),
		.phase (phase)
	);

	chirp_envelope env_i (
		.clk    (clk),
		.reset  (reset),
		.gate   (gate),
		.cfg    (cfg_if.env),
		.amp    (amp),
		.gate_d (gate_d)
	);

	chirp_shaper shaper_i (
		.clk          (clk),
		.reset        (reset),
		.gate_d       (gate_d),
		.phase        (phase),
		.amp          (amp),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	// Burst in progress, straight from the envelope
	assign busy = cfg_if.busy;

endmodule

/* tb_chirp_gen.sv */
// **********************************************************
// Testbench for the linear chirp burst generator
// Wishbone setup, burst runs and per-sample reference checks
// **********************************************************
`timescale 1ns/1ps
`include "chirp_params.svh"

module tb_chirp_gen;

	localparam int NB = 4;
	localparam int CLK_PERIOD = 40;

	logic                          clk;
	logic                          reset;
	logic                          wb_cyc;
	logic                          wb_stb;
	logic                          wb_we;
	logic [`CHIRP_AW-1:0]          wb_adr;
	logic [`CHIRP_DW-1:0]          wb_dat_w;
	logic                          wb_ack;
	logic [`CHIRP_DW-1:0]          wb_dat_r;
	logic [`CHIRP_FW-1:0]          freq;
	logic [`CHIRP_AMPW-1:0]        amp;
	logic signed [`CHIRP_SW-1:0]   sample;
	logic                          sample_valid;
	logic                          busy;

	// Burst settings drawn up front so the watchdog knows the run length
	integer        seed;
	logic [31:0]   b_dur [NB];
	logic [31:0]   b_rate [NB];
	logic [15:0]   b_slope [NB];
	logic [15:0]   b_max [NB];
	logic [23:0]   b_fstart [NB];
	logic [23:0]   b_fstep [NB];
	longint        budget_cycles;
	logic          plan_ready;

	// Reference model state
	logic          env_check;
	logic [15:0]   cur_slope;
	logic [15:0]   cur_max;
	logic [23:0]   cur_fstart;
	logic [23:0]   cur_fstep;
	int unsigned   sample_k;
	logic [15:0]   amp_prev;
	logic          falling;
	logic [23:0]   freq_exp;
	logic [23:0]   phase_exp;
	logic [16:0]   amp_up;
	logic [15:0]   amp_down;
	logic [15:0]   sample_mag;
	real           x_frac;
	real           mag_exp;
	logic [31:0]   rd;

	chirp_gen dut_i (
		.clk          (clk),
		.reset        (reset),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_ack       (wb_ack),
		.wb_dat_r     (wb_dat_r),
		.freq         (freq),
		.amp          (amp),
		.sample       (sample),
		.sample_valid (sample_valid),
		.busy         (busy)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic void report_failure(string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endfunction

	function automatic void value_fail(string name, logic [31:0] got, logic [31:0] exp);
		report_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endfunction

	// One classic cycle driven on falling edges
	// Ack is seen on a later falling edge
	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] data,
		output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = data;
		@(negedge clk);
		while (!wb_ack && waited < 8) begin
			waited++;
			@(negedge clk);
		end
		assert (wb_ack) else report_failure("Wishbone slave never acknowledged the cycle");
		rdata  = wb_dat_r;
		// Reads hold the request one more cycle so a repeated ack would show
		if (!we)
			@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic reg_write(input logic [3:0] adr, input logic [31:0] data);
		logic [31:0] ignored;
		bus_cycle(1'b1, adr, data, ignored);
	endtask

	task automatic reg_read(input logic [3:0] adr, output logic [31:0] data);
		bus_cycle(1'b0, adr, 32'h0, data);
	endtask

	task automatic read_expect(input string name, input logic [3:0] adr, input logic [31:0] exp);
		reg_read(adr, rd);
		assert (rd == exp) else value_fail(name, rd, exp);
	endtask

	task automatic program_burst(input logic [31:0] dur, input logic [31:0] rate,
		input logic [15:0] slope, input logic [15:0] mx,
		input logic [23:0] fstart, input logic [23:0] fstep);
		reg_write(chirp_pkg::DURATION, dur);
		reg_write(chirp_pkg::RATE, rate);
		reg_write(chirp_pkg::AMP_SLOPE, {16'h0, slope});
		reg_write(chirp_pkg::AMP_MAX, {16'h0, mx});
		reg_write(chirp_pkg::FREQ_START, {8'h0, fstart});
		reg_write(chirp_pkg::FREQ_STEP, {8'h0, fstep});
	endtask

	task automatic wait_busy_high();
		int waited;
		waited = 0;
		while (!busy && waited < 8) begin
			waited++;
			@(negedge clk);
		end
		assert (busy) else report_failure("busy did not rise after the start write");
	endtask

	// Wait for the end of the burst
	task automatic wait_busy_low();
		while (busy)
			@(negedge clk);
		// Let the last samples leave the shaper pipeline
		repeat (4) @(negedge clk);
	endtask

	task automatic register_readback();
		logic [31:0] wr_val [8];
		int a;
		for (a = 2; a < 8; a++) begin
			wr_val[a] = $random(seed);
			reg_write(4'(a), wr_val[a]);
		end
		read_expect("DURATION", chirp_pkg::DURATION, wr_val[2]);
		read_expect("AMP_SLOPE", chirp_pkg::AMP_SLOPE, {16'h0, wr_val[3][15:0]});
		read_expect("AMP_MAX", chirp_pkg::AMP_MAX, {16'h0, wr_val[4][15:0]});
		read_expect("FREQ_START", chirp_pkg::FREQ_START, {8'h0, wr_val[5][23:0]});
		read_expect("FREQ_STEP", chirp_pkg::FREQ_STEP, {8'h0, wr_val[6][23:0]});
		read_expect("RATE", chirp_pkg::RATE, wr_val[7]);
		// STATUS is read-only and idle here
		reg_write(chirp_pkg::STATUS, 32'hFFFF_FFFF);
		read_expect("STATUS", chirp_pkg::STATUS, 32'h0);
		for (a = 8; a < 16; a++) begin
			reg_write(4'(a), $random(seed));
			read_expect("unmapped word", 4'(a), 32'h0);
		end
	endtask

	task automatic run_burst(input int i);
		program_burst(b_dur[i], b_rate[i], b_slope[i], b_max[i], b_fstart[i], b_fstep[i]);
		cur_slope  = b_slope[i];
		cur_max    = b_max[i];
		cur_fstart = b_fstart[i];
		cur_fstep  = b_fstep[i];
		sample_k   = 0;
		amp_prev   = '0;
		falling    = 1'b0;
		freq_exp   = '0;
		phase_exp  = '0;
		env_check  = 1'b1;
		reg_write(chirp_pkg::CTRL, 32'h1);
		wait_busy_high();
		wait_busy_low();
		// The counter steps once per strobe from DURATION down to zero
		assert (sample_k >= b_dur[i]) else value_fail("sample count", sample_k, b_dur[i]);
		read_expect("STATUS", chirp_pkg::STATUS, 32'h0);
		env_check = 1'b0;
	endtask

	task automatic restart_warning_burst();
		program_burst(32'd200, 32'd4, 16'h2000, 16'hC000, 24'h010000, 24'h000100);
		reg_write(chirp_pkg::CTRL, 32'h1);
		wait_busy_high();
		// Hold phase at the ceiling
		while (amp != 16'hC000)
			@(negedge clk);
		repeat (8) @(negedge clk);
		reg_write(chirp_pkg::CTRL, 32'h1);
		wait_busy_low();
		read_expect("STATUS", chirp_pkg::STATUS, 32'(1) << chirp_pkg::STAT_WARNING);
		reg_write(chirp_pkg::CTRL, 32'h2);
		read_expect("STATUS", chirp_pkg::STATUS, 32'h0);
	endtask

	task automatic overlap_error_burst();
		// RATE 1 puts strobes on adjacent cycles
		program_burst(32'd40, 32'd1, 16'h1000, 16'h8000, 24'h020000, 24'h000010);
		reg_write(chirp_pkg::CTRL, 32'h1);
		wait_busy_high();
		wait_busy_low();
		read_expect("STATUS", chirp_pkg::STATUS, 32'(1) << chirp_pkg::STAT_ERROR);
		reg_write(chirp_pkg::CTRL, 32'h2);
		read_expect("STATUS", chirp_pkg::STATUS, 32'h0);
	endtask

	// Reference models step once per output sample
	always @(negedge clk) begin
		if (env_check && sample_valid) begin
			sample_k++;
			freq_exp  = (sample_k == 1) ? cur_fstart : freq_exp + cur_fstep;
			phase_exp = phase_exp + freq_exp;
			amp_up    = {1'b0, amp_prev} + {1'b0, cur_slope};
			if (amp_up > {1'b0, cur_max})
				amp_up = {1'b0, cur_max};
			amp_down  = (amp_prev > cur_slope) ? amp_prev - cur_slope : 16'h0;
			// First step down marks the start of the fall
			if (!falling && amp != amp_up[15:0] && amp == amp_down)
				falling = 1'b1;
			assert (freq == freq_exp) else value_fail("freq", 32'(freq), 32'(freq_exp));
			assert (amp <= cur_max) else value_fail("amp", 32'(amp), 32'(cur_max));
			if (falling) begin
				assert (amp == amp_down) else value_fail("amp", 32'(amp), 32'(amp_down));
			end else begin
				assert (amp == amp_up[15:0]) else value_fail("amp", 32'(amp), 32'(amp_up));
			end
			sample_mag = sample[15] ? ~sample + 1'b1 : sample;
			if (amp == 16'h0) begin
				assert (sample == 0) else value_fail("sample", 32'(sample), 32'h0);
			end
			// Half-wave parabola 4x(1-x) at half the amplitude
			// Shaper truncation stays within a few LSBs
			x_frac  = $itor(phase_exp[22:0]) / 8388608.0;
			mag_exp = 2.0 * x_frac * (1.0 - x_frac) * $itor(amp);
			assert ($itor(sample_mag) > mag_exp - 8.0 && $itor(sample_mag) < mag_exp + 8.0)
				else value_fail("sample", 32'(sample_mag), 32'($rtoi(mag_exp)));
			// Sign follows the upper half of the phase circle
			if (phase_exp[23]) begin
				assert (sample <= 0) else value_fail("sample", 32'(sample), 32'h0);
			end else begin
				assert (sample >= 0) else value_fail("sample", 32'(sample), 32'h0);
			end
			amp_prev = amp;
		end
	end

	// Single-cycle ack for each request
	assert property (@(posedge clk) disable iff (reset)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else value_fail("wb_ack", 32'h0, 32'h1);
	assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
		else value_fail("wb_ack", 32'h1, 32'h0);

	// Envelope back at zero by the end of a burst
	assert property (@(posedge clk) disable iff (reset || !env_check) $fell(busy) |-> amp == '0)
		else value_fail("amp", 32'(amp), 32'h0);
	assert property (@(posedge clk) disable iff (reset || !env_check) amp <= cur_max)
		else value_fail("amp", 32'(amp), 32'(cur_max));

	initial begin
		int i;
		logic [31:0] r;
		seed       = 70;
		plan_ready = 1'b0;
		env_check  = 1'b0;
		reset      = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		cur_slope  = '0;
		cur_max    = '0;
		cur_fstart = '0;
		cur_fstep  = '0;
		// Register traffic and the two fault bursts
		budget_cycles = 4000 + 3 * (2 * 200 * 4 + 40);
		for (i = 0; i < NB; i++) begin
			r           = $random(seed);
			b_rate[i]   = 32'd3 + {30'd0, r[1:0]};
			b_dur[i]    = 32'd16 + {25'd0, r[8:2]};
			r           = $random(seed);
			b_slope[i]  = 16'h0400 + {4'h0, r[11:0]};
			b_max[i]    = {1'b1, r[26:12]};
			r           = $random(seed);
			b_fstart[i] = r[23:0];
			r           = $random(seed);
			b_fstep[i]  = r[23:0];
			// The fall may run past DURATION
			// Three times the nominal length covers it
			budget_cycles += 3 * longint'(b_dur[i]) * longint'(b_rate[i]) + 200;
		end
		plan_ready = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert (!wb_ack && !sample_valid && !busy)
			else report_failure("Control outputs were not low after reset");
		assert (amp == '0) else value_fail("amp", 32'(amp), 32'h0);
		assert (sample == '0) else value_fail("sample", 32'(sample), 32'h0);
		register_readback();
		for (i = 0; i < NB; i++)
			run_burst(i);
		restart_warning_burst();
		overlap_error_burst();
		$display("Testbench passed");
		$finish;
	end

	// Watchdog sized from the drawn bursts
	initial begin
		wait (plan_ready);
		#(budget_cycles * CLK_PERIOD);
		report_failure("Timeout, the run did not finish within the expected time");
	end

endmodule

/* chirp_gen.f */
+incdir+.
chirp_pkg.sv
chirp_cfg_if.sv
chirp_wb_regs.sv
chirp_envelope.sv
chirp_sweep.sv
chirp_shaper.sv
chirp_gen.sv
tb_chirp_gen.sv

/* Makefile */
TOP = tb_chirp_gen

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f chirp_gen.f --top-module chirp_gen

sim:
	verilator --binary --timing --assert -f chirp_gen.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
